/* Makefile */
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output and the log"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module hist_tb \
		-f flist.f -Mdir obj_dir
	./obj_dir/Vhist_tb > sim.log 2>&1 || echo "sim failed" >> sim.log
	@cat sim.log
	@if grep -q "sim failed" sim.log; then \
		echo "FAIL"; exit 1; \
	else \
		echo "PASS"; \
	fi

clean:
	rm -rf obj_dir sim.log

/* common/bin_ram_if.sv */
`include "hist_settings.svh"

interface bin_ram_if;

    logic                        acc_en;      // accumulate strobe.
    logic [`HIST_BIN_W-1:0]      acc_bin;
    logic [`HIST_WEIGHT_W-1:0]   acc_weight;
    logic                        rd_en;       // read-and-clear strobe.
    logic [`HIST_BIN_W-1:0]      rd_bin;
    logic                        clr_en;      // plain clear strobe.
    logic [`HIST_BIN_W-1:0]      clr_bin;
    logic                        rd_valid;    // read data returned.
    logic [`HIST_COUNT_W-1:0]    rd_count;

    // controller side.
    modport rq (
        output acc_en, acc_bin, acc_weight,
        output rd_en, rd_bin,
        output clr_en, clr_bin,
        input  rd_valid
    );

    // memory side.
    modport mem (
        input  acc_en, acc_bin, acc_weight,
        input  rd_en, rd_bin,
        input  clr_en, clr_bin,
        output rd_valid, rd_count
    );

    // observer of returned reads.
    modport watch (
        input  rd_valid, rd_count
    );

endinterface

/* common/hist_pkg.sv */
`include "hist_settings.svh"

package hist_pkg;

    // marker codes, upper two bits of a marker word.
    typedef enum logic [1:0] {
        mk_close = 2'b00,  // read out and clear.
        mk_drop  = 2'b01,  // clear, no output.
        mk_rsv_2 = 2'b10,  // ignored.
        mk_rsv_3 = 2'b11   // ignored.
    } marker_kind_e;

    // one event word, decoded as a hit or as a marker
    // depending on the marker flag that travels beside it.
    typedef union packed {
        struct packed {
            logic [`HIST_WEIGHT_W-1:0] weight;  // added to the bin.
            logic [`HIST_BIN_W-1:0]    bin;     // target bin.
        } bin_view;
        struct packed {
            marker_kind_e              kind;    // close or drop.
            logic [`HIST_PIXEL_W-1:0]  pixel;   // pixel id.
        } marker_view;
    } hist_evt_u;

endpackage

/* common/hist_settings.svh */
`ifndef HIST_SETTINGS_SVH
`define HIST_SETTINGS_SVH

// ~~~~~~~~~~~~~~~~~~~~
// histogram geometry
// ~~~~~~~~~~~~~~~~~~~~

`define HIST_NUM_BINS    16   // bins per pixel.
`define HIST_BIN_W       4    // bin address bits.
`define HIST_COUNT_W     8    // counter bits.
`define HIST_COUNT_MAX   255  // saturation value.

// ~~~~~~~~~~~~~~~~~~~~
// event word fields
// ~~~~~~~~~~~~~~~~~~~~

`define HIST_WEIGHT_W    4    // hit weight bits.
`define HIST_PIXEL_W     6    // pixel id bits.

// ~~~~~~~~~~~~~~~~~~~~
// stream credits
// ~~~~~~~~~~~~~~~~~~~~

`define HIST_EVT_DEPTH   4    // input queue, same as sender credits.
`define HIST_OUT_CREDITS 4    // slots held by the consumer.

`endif

/* flist.f */
+incdir+common
common/hist_pkg.sv
common/bin_ram_if.sv
hist_builder/hist_ctrl.sv
hist_builder/bin_counter_ram.sv
hist_builder/peak_finder.sv
src/hist_top.sv
tests/hist_chk.sv
tests/hist_monitor.sv
tests/hist_tb.sv

/* hist_builder/bin_counter_ram.sv */
`include "hist_settings.svh"

module bin_counter_ram (
    input  logic                   clk,
    input  logic                   res,
    bin_ram_if.mem                 ram,
    output logic [`HIST_BIN_W-1:0] rd_bin_out
);

    logic [`HIST_COUNT_W-1:0]  mem [`HIST_NUM_BINS];

    logic                      req_any;
    logic [`HIST_BIN_W-1:0]    req_bin;
    logic                      fwd;

    logic                      s1_valid;
    logic                      s1_acc;
    logic                      s1_rd;
    logic [`HIST_BIN_W-1:0]    s1_bin;
    logic [`HIST_WEIGHT_W-1:0] s1_weight;
    logic [`HIST_COUNT_W-1:0]  s1_old;
    logic [`HIST_COUNT_W:0]    s1_sum;
    logic [`HIST_COUNT_W-1:0]  s1_new;

    // ~~~~~~~~~~~~~~~~~~~~
    // request select
    // ~~~~~~~~~~~~~~~~~~~~

    assign req_any = ram.acc_en || ram.rd_en || ram.clr_en;

    always_comb begin
        if (ram.acc_en) begin
            req_bin = ram.acc_bin;
        end else if (ram.rd_en) begin
            req_bin = ram.rd_bin;
        end else begin
            req_bin = ram.clr_bin;
        end
    end

    // stage 1 writes back this cycle, so its result bypasses the array.
    assign fwd = s1_valid && (s1_bin == req_bin);

    // ~~~~~~~~~~~~~~~~~~~~
    // stage 1 compute
    // ~~~~~~~~~~~~~~~~~~~~

    assign s1_sum = {1'b0, s1_old} + (`HIST_COUNT_W + 1)'(s1_weight);

    always_comb begin
        if (!s1_acc) begin
            s1_new = '0;  // read and clear both leave zero.
        end else if (s1_sum > `HIST_COUNT_MAX) begin
            s1_new = `HIST_COUNT_W'(`HIST_COUNT_MAX);
        end else begin
            s1_new = s1_sum[`HIST_COUNT_W-1:0];
        end
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            s1_valid     <= 1'b0;
            s1_acc       <= 1'b0;
            s1_rd        <= 1'b0;
            ram.rd_valid <= 1'b0;
        end else begin
            s1_valid     <= req_any;
            s1_acc       <= ram.acc_en;
            s1_rd        <= ram.rd_en;
            ram.rd_valid <= s1_rd;  // two cycles after the read.
        end
    end

    always_ff @(posedge clk) begin
        if (req_any) begin
            s1_bin    <= req_bin;
            s1_weight <= ram.acc_weight;
            s1_old    <= fwd ? s1_new : mem[req_bin];
        end
        if (s1_valid) begin
            mem[s1_bin] <= s1_new;
        end
        if (s1_rd) begin
            ram.rd_count <= s1_old;
            rd_bin_out   <= s1_bin;
        end
    end

endmodule

/* hist_builder/hist_ctrl.sv */
`include "hist_settings.svh"

module hist_ctrl (
    input  logic                      clk,
    input  logic                      res,
    input  logic                      evt_valid,
    input  hist_pkg::hist_evt_u       evt_word,
    input  logic                      evt_marker,
    output logic                      evt_credit,
    input  logic                      hist_credit,
    bin_ram_if.rq                     ram,
    output logic                      scan_start,
    output logic [`HIST_PIXEL_W-1:0]  cur_pixel
);
    import hist_pkg::*;

    localparam int q_aw  = $clog2(`HIST_EVT_DEPTH);
    localparam int oc_w  = $clog2(`HIST_OUT_CREDITS + 1);
    localparam int rp_w  = $clog2(`HIST_NUM_BINS + 1);
    localparam int evt_w = $bits(hist_evt_u) + 1;

    localparam logic [2:0] clear_all   = 3'd0;
    localparam logic [2:0] count_input = 3'd1;
    localparam logic [2:0] drain       = 3'd2;
    localparam logic [2:0] readout     = 3'd3;
    localparam logic [2:0] drop_clear  = 3'd4;

    logic [evt_w-1:0]       q_mem [`HIST_EVT_DEPTH];
    logic [q_aw-1:0]        q_wr;
    logic [q_aw-1:0]        q_rd;
    logic [q_aw:0]          q_cnt;
    logic                   q_pop;
    logic                   head_marker;
    hist_evt_u              head_evt;

    logic [2:0]             state;
    logic [`HIST_BIN_W-1:0] bin_ptr;
    logic                   last_bin;
    logic                   rd_all;
    logic                   rd_issue;
    logic                   acc_d1;
    logic [oc_w-1:0]        out_cred;
    logic [rp_w-1:0]        rd_pend;
    logic [rp_w-1:0]        rd_pend_nxt;

    // ~~~~~~~~~~~~~~~~~~~~
    // event queue
    // ~~~~~~~~~~~~~~~~~~~~

    assign q_pop = (state == count_input) && (q_cnt != '0);
    assign {head_marker, head_evt} = q_mem[q_rd];

    always_ff @(posedge clk) begin
        if (evt_valid) begin
            q_mem[q_wr] <= {evt_marker, evt_word};
        end
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            q_wr       <= '0;
            q_rd       <= '0;
            q_cnt      <= '0;
            evt_credit <= 1'b0;
        end else begin
            if (evt_valid) begin
                q_wr <= q_wr + 1'b1;
            end
            if (q_pop) begin
                q_rd <= q_rd + 1'b1;
            end
            if (evt_valid && !q_pop) begin
                q_cnt <= q_cnt + 1'b1;
            end else if (!evt_valid && q_pop) begin
                q_cnt <= q_cnt - 1'b1;
            end
            evt_credit <= q_pop;  // one credit back per pop.
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // output credits
    // ~~~~~~~~~~~~~~~~~~~~

    assign rd_issue = (state == readout) && !rd_all && (out_cred != '0);
    assign last_bin = (bin_ptr == `HIST_BIN_W'(`HIST_NUM_BINS - 1));

    // reads issued but not yet returned.
    always_comb begin
        rd_pend_nxt = rd_pend;
        if (ram.rd_en && !ram.rd_valid) begin
            rd_pend_nxt = rd_pend + 1'b1;
        end else if (!ram.rd_en && ram.rd_valid) begin
            rd_pend_nxt = rd_pend - 1'b1;
        end
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            out_cred <= oc_w'(`HIST_OUT_CREDITS);
            rd_pend  <= '0;
        end else begin
            if (hist_credit && !rd_issue) begin
                out_cred <= out_cred + 1'b1;
            end else if (!hist_credit && rd_issue) begin
                out_cred <= out_cred - 1'b1;  // slot reserved at issue.
            end
            rd_pend <= rd_pend_nxt;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // control FSM
    // ~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state          <= clear_all;
            bin_ptr        <= '0;
            rd_all         <= 1'b0;
            acc_d1         <= 1'b0;
            scan_start     <= 1'b0;
            cur_pixel      <= '0;
            ram.acc_en     <= 1'b0;
            ram.acc_bin    <= '0;
            ram.acc_weight <= '0;
            ram.rd_en      <= 1'b0;
            ram.rd_bin     <= '0;
            ram.clr_en     <= 1'b0;
            ram.clr_bin    <= '0;
        end else begin
            ram.acc_en <= 1'b0;
            ram.rd_en  <= 1'b0;
            ram.clr_en <= 1'b0;
            scan_start <= 1'b0;
            acc_d1     <= ram.acc_en;  // accumulate still in ram stage 1.
            case (state)
                clear_all, drop_clear: begin
                    ram.clr_en  <= 1'b1;
                    ram.clr_bin <= bin_ptr;
                    bin_ptr     <= bin_ptr + 1'b1;
                    if (last_bin) begin
                        state <= count_input;
                    end
                end
                count_input: begin
                    if (q_pop && head_marker) begin
                        case (head_evt.marker_view.kind)
                            mk_close: begin
                                cur_pixel <= head_evt.marker_view.pixel;
                                state     <= drain;
                            end
                            mk_drop: state <= drop_clear;
                            default: state <= count_input;  // reserved codes.
                        endcase
                    end else if (q_pop) begin
                        ram.acc_en     <= 1'b1;
                        ram.acc_bin    <= head_evt.bin_view.bin;
                        ram.acc_weight <= head_evt.bin_view.weight;
                    end
                end
                drain: begin
                    if (!acc_d1) begin
                        state      <= readout;
                        scan_start <= 1'b1;
                        rd_all     <= 1'b0;
                    end
                end
                readout: begin
                    if (rd_issue) begin
                        ram.rd_en  <= 1'b1;
                        ram.rd_bin <= bin_ptr;
                        bin_ptr    <= bin_ptr + 1'b1;
                        rd_all     <= last_bin;
                    end
                    if (rd_all && rd_pend_nxt == '0) begin
                        state <= count_input;  // last bin is back.
                    end
                end
                default: state <= clear_all;
            endcase
        end
    end

endmodule

/* hist_builder/peak_finder.sv */
`include "hist_settings.svh"

module peak_finder (
    input  logic                      clk,
    input  logic                      res,
    bin_ram_if.watch                  ram,
    input  logic [`HIST_BIN_W-1:0]    rd_bin,
    input  logic                      scan_start,
    input  logic [`HIST_PIXEL_W-1:0]  pixel,
    output logic                      peak_valid,
    output logic [`HIST_PIXEL_W-1:0]  peak_pixel,
    output logic [`HIST_BIN_W-1:0]    peak_bin,
    output logic [`HIST_COUNT_W-1:0]  peak_count
);

    logic [`HIST_COUNT_W-1:0] best_count;
    logic [`HIST_BIN_W-1:0]   best_bin;
    logic [`HIST_PIXEL_W-1:0] scan_pixel;
    logic                     take;
    logic [`HIST_COUNT_W-1:0] cand_count;
    logic [`HIST_BIN_W-1:0]   cand_bin;
    logic                     scan_end;

    // strictly greater only, so ties stay on the lower bin.
    assign take       = ram.rd_count > best_count;
    assign cand_count = take ? ram.rd_count : best_count;
    assign cand_bin   = take ? rd_bin : best_bin;
    assign scan_end   = ram.rd_valid && (rd_bin == `HIST_BIN_W'(`HIST_NUM_BINS - 1));

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            peak_valid <= 1'b0;
        end else begin
            peak_valid <= scan_end;
        end
    end

    always_ff @(posedge clk) begin
        if (scan_start) begin
            best_count <= '0;
            best_bin   <= '0;
            scan_pixel <= pixel;  // held for the whole readout.
        end else if (ram.rd_valid) begin
            best_count <= cand_count;
            best_bin   <= cand_bin;
        end
        if (scan_end) begin
            peak_pixel <= scan_pixel;
            peak_bin   <= cand_bin;
            peak_count <= cand_count;
        end
    end

endmodule

/* src/hist_top.sv */
`include "hist_settings.svh"

module hist_top (
    input  logic                      clk,
    input  logic                      res,
    input  logic                      evt_valid,
    input  hist_pkg::hist_evt_u       evt_word,
    input  logic                      evt_marker,
    output logic                      evt_credit,
    output logic                      hist_valid,
    output logic [`HIST_PIXEL_W-1:0]  hist_pixel,
    output logic [`HIST_BIN_W-1:0]    hist_bin,
    output logic [`HIST_COUNT_W-1:0]  hist_count,
    input  logic                      hist_credit,
    output logic                      peak_valid,
    output logic [`HIST_PIXEL_W-1:0]  peak_pixel,
    output logic [`HIST_BIN_W-1:0]    peak_bin,
    output logic [`HIST_COUNT_W-1:0]  peak_count
);

    logic                     scan_start;
    logic [`HIST_PIXEL_W-1:0] cur_pixel;
    logic [`HIST_BIN_W-1:0]   rd_bin_out;

    bin_ram_if ram_bus ();

    hist_ctrl u_ctrl (
        .clk         (clk),
        .res         (res),
        .evt_valid   (evt_valid),
        .evt_word    (evt_word),
        .evt_marker  (evt_marker),
        .evt_credit  (evt_credit),
        .hist_credit (hist_credit),
        .ram         (ram_bus.rq),
        .scan_start  (scan_start),
        .cur_pixel   (cur_pixel)
    );

    bin_counter_ram u_ram (
        .clk        (clk),
        .res        (res),
        .ram        (ram_bus.mem),
        .rd_bin_out (rd_bin_out)
    );

    peak_finder u_peak (
        .clk        (clk),
        .res        (res),
        .ram        (ram_bus.watch),
        .rd_bin     (rd_bin_out),
        .scan_start (scan_start),
        .pixel      (cur_pixel),
        .peak_valid (peak_valid),
        .peak_pixel (peak_pixel),
        .peak_bin   (peak_bin),
        .peak_count (peak_count)
    );

    // output stream is the read return path.
    assign hist_valid = ram_bus.rd_valid;
    assign hist_count = ram_bus.rd_count;
    assign hist_bin   = rd_bin_out;
    assign hist_pixel = cur_pixel;

endmodule

/* tests/hist_chk.sv */
`include "hist_settings.svh"

module hist_chk (
    input logic clk,
    input logic res,
    input logic evt_valid,
    input logic evt_credit,
    input logic hist_valid,
    input logic hist_credit,
    input logic peak_valid
);

    int out_cred;       // consumer slots as seen on the pins.
    int in_cred;        // sender credits as seen on the pins.
    int fail_out  = 0;
    int fail_in   = 0;
    int fail_peak = 0;
    int fail_count;

    assign fail_count = fail_out + fail_in + fail_peak;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            out_cred <= `HIST_OUT_CREDITS;
            in_cred  <= `HIST_EVT_DEPTH;
        end else begin
            out_cred <= out_cred - int'(hist_valid) + int'(hist_credit);
            in_cred  <= in_cred - int'(evt_valid) + int'(evt_credit);
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // stream rules
    // ~~~~~~~~~~~~~~~~~~~~

    out_credit_a: assert property (@(posedge clk) disable iff (!res)
        hist_valid |-> out_cred > 0)
        else begin
            $error("hist_valid sent with no output credit left");
            fail_out <= fail_out + 1;
        end

    in_credit_a: assert property (@(posedge clk) disable iff (!res)
        evt_valid |-> in_cred > 0)
        else begin
            $error("evt_valid driven with no input credit left");
            fail_in <= fail_in + 1;
        end

    peak_apart_a: assert property (@(posedge clk) disable iff (!res)
        !(peak_valid && hist_valid))
        else begin
            $error("peak_valid high in the same cycle as hist_valid");
            fail_peak <= fail_peak + 1;
        end

endmodule

/* tests/hist_monitor.sv */
`include "hist_settings.svh"

module hist_monitor (
    input  logic                      clk,
    input  logic                      res,
    input  logic                      evt_valid,
    input  hist_pkg::hist_evt_u       evt_word,
    input  logic                      evt_marker,
    input  logic                      evt_credit,
    input  logic                      hist_valid,
    input  logic [`HIST_PIXEL_W-1:0]  hist_pixel,
    input  logic [`HIST_BIN_W-1:0]    hist_bin,
    input  logic [`HIST_COUNT_W-1:0]  hist_count,
    input  logic                      peak_valid,
    input  logic [`HIST_PIXEL_W-1:0]  peak_pixel,
    input  logic [`HIST_BIN_W-1:0]    peak_bin,
    input  logic [`HIST_COUNT_W-1:0]  peak_count,
    output int                        err_count,
    output int                        peaks_seen,
    output int                        pending
);
    import hist_pkg::*;

    int model [`HIST_NUM_BINS];   // running histogram of the open pixel.
    int exp_count_q [$];          // 16 counts per closed pixel.
    int exp_pixel_q [$];
    int exp_pbin_q [$];
    int exp_pcount_q [$];
    bit close_q [$];              // accepted events, in pop order.
    bit busy;                     // readout between close pop and peak.
    int bin_idx;
    bit last_now;
    bit was_last;

    task automatic report_mismatch(string name, int expv, int actv);
        $display("** Error: %s expected 0x%0h got 0x%0h at %0t", name, expv, actv, $time);
        err_count++;
    endtask

    task automatic report_fault(string what);
        $display("error: %s at %0t", what, $time);
        err_count++;
    endtask

    // freeze the open pixel into expected output, then start empty.
    task automatic snapshot_pixel(logic [`HIST_PIXEL_W-1:0] pixel);
        int b;
        int best_bin;
        int best_cnt;
        best_bin = 0;
        best_cnt = 0;
        for (b = 0; b < `HIST_NUM_BINS; b++) begin
            exp_count_q.push_back(model[b]);
            if (model[b] > best_cnt) begin
                best_cnt = model[b];  // ties keep the lower bin.
                best_bin = b;
            end
            model[b] = 0;
        end
        exp_pixel_q.push_back(int'(pixel));
        exp_pbin_q.push_back(best_bin);
        exp_pcount_q.push_back(best_cnt);
    endtask

    task automatic take_event(logic marker, hist_evt_u evt);
        int b;
        int sum;
        if (marker) begin
            close_q.push_back(evt.marker_view.kind == mk_close);
            if (evt.marker_view.kind == mk_close) begin
                snapshot_pixel(evt.marker_view.pixel);
            end else if (evt.marker_view.kind == mk_drop) begin
                for (b = 0; b < `HIST_NUM_BINS; b++) begin
                    model[b] = 0;
                end
            end
        end else begin
            close_q.push_back(1'b0);
            sum = model[evt.bin_view.bin] + int'(evt.bin_view.weight);
            model[evt.bin_view.bin] = (sum > `HIST_COUNT_MAX) ? `HIST_COUNT_MAX : sum;
        end
    endtask

    task automatic check_bin();
        int expv;
        if (exp_count_q.size() == 0) begin
            report_fault("hist_valid with no closed pixel waiting");
        end else begin
            expv = exp_count_q.pop_front();
            if (hist_count !== `HIST_COUNT_W'(expv)) begin
                report_mismatch("hist_count", expv, int'(hist_count));
            end
            if (hist_bin !== `HIST_BIN_W'(bin_idx)) begin
                report_mismatch("hist_bin", bin_idx, int'(hist_bin));
            end
            if (hist_pixel !== `HIST_PIXEL_W'(exp_pixel_q[0])) begin
                report_mismatch("hist_pixel", exp_pixel_q[0], int'(hist_pixel));
            end
            bin_idx++;
            if (bin_idx == `HIST_NUM_BINS) begin
                bin_idx  = 0;
                last_now = 1'b1;
            end
        end
    endtask

    task automatic check_peak();
        if (exp_pbin_q.size() == 0) begin
            report_fault("peak_valid with no closed pixel waiting");
        end else begin
            if (!was_last) begin
                report_fault("peak_valid not one cycle after the last bin");
            end
            if (peak_pixel !== `HIST_PIXEL_W'(exp_pixel_q[0])) begin
                report_mismatch("peak_pixel", exp_pixel_q[0], int'(peak_pixel));
            end
            if (peak_bin !== `HIST_BIN_W'(exp_pbin_q[0])) begin
                report_mismatch("peak_bin", exp_pbin_q[0], int'(peak_bin));
            end
            if (peak_count !== `HIST_COUNT_W'(exp_pcount_q[0])) begin
                report_mismatch("peak_count", exp_pcount_q[0], int'(peak_count));
            end
            void'(exp_pixel_q.pop_front());
            void'(exp_pbin_q.pop_front());
            void'(exp_pcount_q.pop_front());
        end
        busy = 1'b0;
        peaks_seen++;
    endtask

    initial begin
        err_count  = 0;
        peaks_seen = 0;
        pending    = 0;
        for (int b = 0; b < `HIST_NUM_BINS; b++) begin
            model[b] = 0;
        end
    end

    // outputs are registered, so the values at the edge are the settled ones.
    always @(posedge clk) begin
        if (!res) begin
            busy     = 1'b0;
            bin_idx  = 0;
            last_now = 1'b0;
        end else begin
            was_last = last_now;
            last_now = 1'b0;
            if (evt_valid) begin
                take_event(evt_marker, evt_word);
            end
            if (evt_credit) begin
                if (busy) begin
                    report_fault("input credit returned during a readout");
                end
                if (close_q.size() == 0) begin
                    report_fault("input credit with no event in the queue");
                end else if (close_q.pop_front()) begin
                    busy = 1'b1;
                end
            end
            if (hist_valid) begin
                check_bin();
            end
            if (peak_valid) begin
                check_peak();
            end
            pending = exp_count_q.size() + exp_pbin_q.size();
        end
    end

endmodule

/* tests/hist_tb.sv */
`include "hist_settings.svh"

module hist_tb;
    import hist_pkg::*;

    localparam int max_lines = 64;
    localparam int max_words = 3 * max_lines;

    logic                     clk = 1'b0;
    logic                     res;
    logic                     evt_valid;
    hist_evt_u                evt_word;
    logic                     evt_marker;
    logic                     evt_credit;
    logic                     hist_valid;
    logic [`HIST_PIXEL_W-1:0] hist_pixel;
    logic [`HIST_BIN_W-1:0]   hist_bin;
    logic [`HIST_COUNT_W-1:0] hist_count;
    logic                     hist_credit;
    logic                     peak_valid;
    logic [`HIST_PIXEL_W-1:0] peak_pixel;
    logic [`HIST_BIN_W-1:0]   peak_bin;
    logic [`HIST_COUNT_W-1:0] peak_count;

    logic [8:0]  stim [max_words];         // flag, word, hold-off per line.
    int          n_lines;
    int          n_close;
    int          in_credits;
    int          tb_errors = 0;
    int          cycle_cnt = 0;
    int          timeout_limit = 32'h7fff_ffff;
    int          bins_out = 0;
    int          hold_q [$];               // hold-off per pending readout.
    int          credit_due [$];           // cycle when each slot goes back.
    logic [31:0] lcg_state = 32'he6e36f35;
    int          mon_errors;
    int          peaks_seen;
    int          pending;

    hist_top DUT (
        .clk(clk), .res(res),
        .evt_valid(evt_valid), .evt_word(evt_word), .evt_marker(evt_marker),
        .evt_credit(evt_credit),
        .hist_valid(hist_valid), .hist_pixel(hist_pixel),
        .hist_bin(hist_bin), .hist_count(hist_count),
        .hist_credit(hist_credit),
        .peak_valid(peak_valid), .peak_pixel(peak_pixel),
        .peak_bin(peak_bin), .peak_count(peak_count)
    );

    hist_monitor u_monitor (
        .clk(clk), .res(res),
        .evt_valid(evt_valid), .evt_word(evt_word), .evt_marker(evt_marker),
        .evt_credit(evt_credit),
        .hist_valid(hist_valid), .hist_pixel(hist_pixel),
        .hist_bin(hist_bin), .hist_count(hist_count),
        .peak_valid(peak_valid), .peak_pixel(peak_pixel),
        .peak_bin(peak_bin), .peak_count(peak_count),
        .err_count(mon_errors), .peaks_seen(peaks_seen), .pending(pending)
    );

    bind hist_top hist_chk u_chk (
        .clk(clk), .res(res),
        .evt_valid(evt_valid), .evt_credit(evt_credit),
        .hist_valid(hist_valid), .hist_credit(hist_credit),
        .peak_valid(peak_valid)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic end_run(int extra);
        int total;
        total = tb_errors + extra + mon_errors + DUT.u_chk.fail_count;
        $display("errors: %0d (testbench %0d, monitor %0d, assertions %0d)",
                 total, tb_errors + extra, mon_errors, DUT.u_chk.fail_count);
        if (total == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // one clock of both streams
    // ~~~~~~~~~~~~~~~~~~~~

    task automatic next_cycle();
        int hold;
        @(posedge clk);
        if (evt_credit) begin
            in_credits++;
        end
        if (hist_valid) begin
            hold = (hold_q.size() != 0) ? hold_q[0] : 0;
            credit_due.push_back(cycle_cnt + hold);
            bins_out++;
            if (bins_out == `HIST_NUM_BINS) begin
                bins_out = 0;
                if (hold_q.size() != 0) begin
                    void'(hold_q.pop_front());
                end
            end
        end
        #1;
        evt_valid   = 1'b0;
        hist_credit = 1'b0;
        if (credit_due.size() != 0 && credit_due[0] <= cycle_cnt) begin
            hist_credit = 1'b1;  // one slot back per cycle at most.
            void'(credit_due.pop_front());
        end
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == timeout_limit) begin
            $display("timeout: run did not finish within %0d cycles", timeout_limit);
            end_run(1);
        end
    end

    initial begin
        logic [31:0] rnd;
        int          line;
        res         = 1'b0;
        evt_valid   = 1'b0;
        evt_word    = '0;
        evt_marker  = 1'b0;
        hist_credit = 1'b0;
        in_credits  = `HIST_EVT_DEPTH;

        for (int i = 0; i < max_words; i++) begin
            stim[i] = {1'b1, 8'(i)};  // bit 8 marks an unused entry.
        end
        $readmemh("tests/hist_testdata.txt", stim);
        n_lines = 0;
        n_close = 0;
        while (n_lines < max_lines && !stim[3 * n_lines][8]) begin
            if (stim[3 * n_lines][0] && stim[3 * n_lines + 1][7:6] == 2'b00) begin
                n_close++;
            end
            n_lines++;
        end
        if (n_lines == 0) begin
            $display("error: no stimulus lines read from the data file");
            tb_errors++;
        end
        timeout_limit = 40 * n_lines + 64;

        repeat (16) next_cycle();
        res = 1'b1;

        for (line = 0; line < n_lines; line++) begin
            next_cycle();
            rnd = lcg_next();
            if (rnd[31:30] == 2'b00) begin
                next_cycle();  // occasional idle cycle.
            end
            while (in_credits == 0) begin
                next_cycle();
            end
            evt_valid  = 1'b1;
            evt_marker = stim[3 * line][0];
            evt_word   = stim[3 * line + 1][7:0];
            in_credits--;
            if (stim[3 * line][0] && stim[3 * line + 1][7:6] == 2'b00) begin
                hold_q.push_back(int'(stim[3 * line + 2]));
            end
        end
        next_cycle();

        while (peaks_seen < n_close || credit_due.size() != 0) begin
            next_cycle();
        end
        repeat (20) next_cycle();  // room for stray output.

        if (in_credits != `HIST_EVT_DEPTH) begin
            $display("error: input credits not all returned, %0d of %0d",
                     in_credits, `HIST_EVT_DEPTH);
            tb_errors++;
        end
        if (pending != 0) begin
            $display("error: %0d expected outputs never appeared", pending);
            tb_errors++;
        end
        end_run(0);
    end

endmodule

/* tests/hist_testdata.txt */
// columns: marker flag, event word (hex), output credit hold-off in cycles
// hit word is weight:bin, marker word is kind:pixel (kind 0 close, 1 drop)
0 13 0
0 25 0
0 2a 0
0 1f 0
0 10 0
1 01 0
0 34 0
0 54 0
0 74 0
0 f6 0
0 f6 0
0 f6 0
0 f6 0
0 f6 0
0 f6 0
0 f6 0
0 f6 0
0 f6 0
0 f6 0
0 f6 0
0 f6 0
0 f6 0
0 f6 0
0 f6 0
0 f6 0
0 f6 0
0 f6 0
0 19 0
1 02 6
0 18 0
0 2b 0
1 45 0
0 11 0
0 31 0
0 2e 0
1 83 0
1 03 3
